/* design/lcd_pkg.sv */
/* shared types and constants for the 4x20 serial LCD controller
   init table follows the SSD1803 sequence for an 8-bit, 4-line panel */
package lcd_pkg;

	// widths with a meaning of their own
	typedef logic [7:0] bus_byte_t;
	typedef logic [7:0] char_t;
	typedef logic [6:0] char_addr_t;
	typedef logic [3:0] nibble_t;

	// control nibbles, high half of the start byte
	localparam nibble_t ctrl_command = 4'b0001;
	localparam nibble_t ctrl_data    = 4'b0101;
	localparam nibble_t ctrl_read    = 4'b0011;

	// busy flag position in the status byte
	localparam int busy_bit = 7;

	// init commands as control nibble, low nibble, high nibble
	localparam int init_num_commands = 22;
	localparam nibble_t init_table [0:init_num_commands*3-1] = '{
		ctrl_command, 4'b1011, 4'b0011,
		ctrl_command, 4'b0010, 4'b0000,
		ctrl_command, 4'b0110, 4'b0000,
		ctrl_command, 4'b1001, 4'b0000,
		ctrl_command, 4'b0000, 4'b0001,
		ctrl_command, 4'b0000, 4'b1100,
		// rom select, then its data byte
		ctrl_command, 4'b0010, 4'b0111,
		ctrl_data,    4'b0000, 4'b0000,
		// temperature control, then its data byte
		ctrl_command, 4'b0110, 4'b0111,
		ctrl_data,    4'b0010, 4'b0000,
		ctrl_command, 4'b1010, 4'b0011,
		ctrl_command, 4'b0010, 4'b0001,
		// bias, oscillator, regulator and contrast
		ctrl_command, 4'b1001, 4'b0011,
		ctrl_command, 4'b1011, 4'b0001,
		ctrl_command, 4'b0111, 4'b0101,
		ctrl_command, 4'b0000, 4'b0111,
		ctrl_command, 4'b1110, 4'b0110,
		// entry mode, display on, clear, return home
		ctrl_command, 4'b1000, 4'b0011,
		ctrl_command, 4'b0110, 4'b0000,
		ctrl_command, 4'b1100, 4'b0000,
		ctrl_command, 4'b0001, 4'b0000,
		ctrl_command, 4'b0010, 4'b0000
	};

	// controller states
	typedef enum logic [4:0] {
		st_wait_reset, st_reset, st_resetted,
		st_init_send, st_init_wait,
		st_busy_cmd, st_busy_read, st_busy_done, st_busy_check,
		st_hold_off, st_idle,
		st_home_ctrl, st_home_lo, st_home_hi, st_home_wait,
		st_data_ctrl, st_data
	} lcd_state_t;

endpackage

/* design/text_buffer.sv */
/* character memory, one host write per cycle, read is combinational
   writes at or above LCD_SIZE are dropped, contents survive reset */
`timescale 1ns/1ns

module text_buffer #(
	parameter int LCD_SIZE = 80
) (
	input  logic                in_clk,
	input  logic                wr_en,
	input  lcd_pkg::char_addr_t wr_addr,
	input  lcd_pkg::char_t      wr_char,
	input  lcd_pkg::char_addr_t rd_addr,
	output lcd_pkg::char_t      rd_char
);
	import lcd_pkg::*;

	// one entry per screen position
	char_t mem [0:LCD_SIZE-1];

	// address range checks
	logic wr_in_range;
	logic rd_in_range;

	assign wr_in_range = (wr_addr < LCD_SIZE);
	assign rd_in_range = (rd_addr < LCD_SIZE);

	// ----------------------------------------
	// host write port
	// ----------------------------------------
	always_ff @(posedge in_clk) begin
		if (wr_en && wr_in_range) begin
			mem[wr_addr] <= wr_char;
		end
	end

	// ----------------------------------------
	// controller read port
	// ----------------------------------------
	// out of range reads give a blank code
	always_comb begin
		rd_char = '0;
		if (rd_in_range) begin
			rd_char = mem[rd_addr];
		end
	end

endmodule

/* design/serial_master.sv */
/* byte-wide serial master, sclk = in_clk/4 idling high, lsb first
   data changes on falling sclk, sdi sampled on rising sclk
   cs_n stays low while bus_enable is held at the end of each byte */
`timescale 1ns/1ns

module serial_master (
	input  logic               in_clk,
	input  logic               in_rst,
	input  logic               bus_enable,
	input  lcd_pkg::bus_byte_t tx_byte,
	output logic               byte_next,
	output logic               bus_ready,
	output lcd_pkg::bus_byte_t rx_byte,
	output logic               cs_n,
	output logic               sclk,
	output logic               sdo,
	input  logic               sdi
);
	import lcd_pkg::*;

	// idle, one setup cycle with cs_n low, then shifting
	typedef enum logic [1:0] {sm_idle, sm_lead, sm_shift} sm_state_t;

	sm_state_t state;
	logic [1:0] phase;
	logic [2:0] bit_cnt;
	logic byte_next_q;
	logic cs_n_q;
	logic sclk_q;
	logic sdo_q;
	bus_byte_t tx_shift;
	bus_byte_t rx_shift;
	bus_byte_t rx_byte_q;

	// phase 0,1 sclk low; phase 2,3 sclk high
	logic load_idle;
	logic bit_end;
	logic byte_end;
	logic load_next;
	logic sample;

	assign load_idle = (state == sm_idle) && bus_enable;
	assign bit_end   = (state == sm_shift) && (phase == 2'd3);
	assign byte_end  = bit_end && (bit_cnt == 3'd7);
	assign load_next = byte_end && bus_enable;
	assign sample    = (state == sm_shift) && (phase == 2'd1);

	// ----------------------------------------
	// control and line registers
	// ----------------------------------------
	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			state       <= sm_idle;
			phase       <= 2'd0;
			bit_cnt     <= 3'd0;
			byte_next_q <= 1'b0;
			cs_n_q      <= 1'b1;
			sclk_q      <= 1'b1;
			sdo_q       <= 1'b0;
		end else begin
			byte_next_q <= 1'b0;
			unique case (state)
				sm_idle: begin
					if (load_idle) begin
						byte_next_q <= 1'b1;
						cs_n_q      <= 1'b0;
						state       <= sm_lead;
					end
				end
				sm_lead: begin
					// first falling edge with bit 0
					sclk_q  <= 1'b0;
					sdo_q   <= tx_shift[0];
					phase   <= 2'd0;
					bit_cnt <= 3'd0;
					state   <= sm_shift;
				end
				sm_shift: begin
					phase <= phase + 2'd1;
					if (sample) begin
						sclk_q <= 1'b1;
					end
					if (load_next) begin
						// back-to-back byte, chip select held
						byte_next_q <= 1'b1;
						sclk_q      <= 1'b0;
						sdo_q       <= tx_byte[0];
						bit_cnt     <= 3'd0;
					end else if (byte_end) begin
						cs_n_q <= 1'b1;
						state  <= sm_idle;
					end else if (bit_end) begin
						sclk_q  <= 1'b0;
						sdo_q   <= tx_shift[1];
						bit_cnt <= bit_cnt + 3'd1;
					end
				end
				default: state <= sm_idle;
			endcase
		end
	end

	// ----------------------------------------
	// shift registers, no reset needed
	// ----------------------------------------
	always_ff @(posedge in_clk) begin
		if (load_idle || load_next) begin
			tx_shift <= tx_byte;
		end else if (bit_end) begin
			tx_shift <= {1'b0, tx_shift[7:1]};
		end
		// lsb arrives first, shifts down to bit 0
		if (sample) begin
			rx_shift <= {sdi, rx_shift[7:1]};
		end
		if (byte_end) begin
			rx_byte_q <= rx_shift;
		end
	end

	assign bus_ready = (state == sm_idle);
	assign byte_next = byte_next_q;
	assign rx_byte   = rx_byte_q;
	assign cs_n      = cs_n_q;
	assign sclk      = sclk_q;
	assign sdo       = sdo_q;

endmodule

/* design/lcd_3wire.sv */
/* LCD controller: power-up reset, 22 init commands, refresh on request
   READ_BUSY_FLAG selects busy polling or fixed 100 us waits
   CLK_HZ should be a multiple of 1000 for the timer lengths */
`timescale 1ns/1ns

module lcd_3wire #(
	parameter int CLK_HZ         = 50000000,
	parameter int LCD_SIZE       = 80,
	parameter int READ_BUSY_FLAG = 1
) (
	input  logic                in_clk,
	input  logic                in_rst,
	output logic                lcd_reset_n,
	input  logic                update_req,
	output logic                update_ack,
	input  logic                bus_ready,
	input  logic                byte_next,
	output logic                bus_enable,
	output lcd_pkg::bus_byte_t  tx_byte,
	input  lcd_pkg::bus_byte_t  rx_byte,
	output lcd_pkg::bus_byte_t  busy_flag,
	output lcd_pkg::char_addr_t rd_addr,
	input  lcd_pkg::char_t      rd_char
);
	import lcd_pkg::*;

	// timer lengths in cycles
	localparam int wait_prereset = CLK_HZ / 1000 * 50;
	localparam int wait_reset    = CLK_HZ / 1000 * 500 / 1000;
	localparam int wait_resetted = CLK_HZ / 1000;
	localparam int wait_cmd      = CLK_HZ / 1000 * 100 / 1000;
	localparam int wait_update   = CLK_HZ / 1000 * 100;
	localparam int timer_w       = $clog2(wait_update) + 1;

	lcd_state_t state, state_nx;
	// where to go once the busy flag clears
	lcd_state_t ret_state, ret_nx;

	// free-running timer, wraps at wait_max
	logic [timer_w-1:0] wait_counter;
	logic [timer_w-1:0] wait_max;

	logic [$clog2(init_num_commands):0] init_cycle, init_nx;
	logic [1:0] cmd_byte, cmd_nx;
	logic [$clog2(LCD_SIZE):0] write_cycle, write_nx;
	bus_byte_t busy_flag_q, flag_nx;
	logic update_ack_q;
	logic accept;
	int init_idx;

	assign init_idx = 3 * init_cycle + cmd_byte;

	// ----------------------------------------
	// registers
	// ----------------------------------------
	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			state        <= st_wait_reset;
			ret_state    <= st_wait_reset;
			wait_counter <= '0;
			init_cycle   <= '0;
			cmd_byte     <= '0;
			write_cycle  <= '0;
			busy_flag_q  <= '0;
			update_ack_q <= 1'b0;
		end else begin
			state       <= state_nx;
			ret_state   <= ret_nx;
			init_cycle  <= init_nx;
			cmd_byte    <= cmd_nx;
			write_cycle <= write_nx;
			busy_flag_q <= flag_nx;
			if (wait_counter == wait_max) begin
				wait_counter <= '0;
			end else begin
				wait_counter <= wait_counter + 1'b1;
			end
			// four-phase ack, drops once the host releases req
			if (accept) begin
				update_ack_q <= 1'b1;
			end else if (!update_req) begin
				update_ack_q <= 1'b0;
			end
		end
	end

	// ----------------------------------------
	// next state and bus outputs
	// ----------------------------------------
	always_comb begin
		state_nx    = state;
		ret_nx      = ret_state;
		init_nx     = init_cycle;
		cmd_nx      = cmd_byte;
		write_nx    = write_cycle;
		flag_nx     = busy_flag_q;
		wait_max    = '0;
		lcd_reset_n = 1'b1;
		rd_addr     = '0;
		bus_enable  = 1'b0;
		tx_byte     = '0;
		accept      = 1'b0;

		unique case (state)
			// power-up: wait, reset pulse, wait
			st_wait_reset: begin
				wait_max = timer_w'(wait_prereset - 1);
				if (wait_counter == wait_max) state_nx = st_reset;
			end
			st_reset: begin
				lcd_reset_n = 1'b0;
				wait_max    = timer_w'(wait_reset - 1);
				if (wait_counter == wait_max) state_nx = st_resetted;
			end
			st_resetted: begin
				wait_max = timer_w'(wait_resetted - 1);
				if (wait_counter == wait_max) state_nx = st_init_send;
			end

			// one command frame: control byte, low nibble, high nibble
			st_init_send: begin
				if (cmd_byte == 2'd3) begin
					// last byte still on the line
					if (bus_ready) begin
						state_nx = st_init_wait;
						init_nx  = init_cycle + 1'b1;
						cmd_nx   = '0;
					end
				end else if (init_cycle == init_num_commands) begin
					state_nx = st_hold_off;
					init_nx  = '0;
				end else begin
					bus_enable = 1'b1;
					if (cmd_byte == 2'd0) begin
						tx_byte = {init_table[init_idx], 4'b1111};
					end else begin
						tx_byte = {4'b0000, init_table[init_idx]};
					end
					if (byte_next) cmd_nx = cmd_byte + 1'b1;
				end
			end
			st_init_wait: begin
				if (READ_BUSY_FLAG != 0) begin
					state_nx = st_busy_cmd;
					ret_nx   = st_init_send;
				end else begin
					wait_max = timer_w'(wait_cmd - 1);
					if (wait_counter == wait_max) state_nx = st_init_send;
				end
			end

			// status read frame, control byte then one dummy byte
			st_busy_cmd: begin
				bus_enable = 1'b1;
				tx_byte    = {ctrl_read, 4'b1111};
				if (byte_next) state_nx = st_busy_read;
			end
			st_busy_read: begin
				bus_enable = 1'b1;
				tx_byte    = 8'h00;
				if (byte_next) state_nx = st_busy_done;
			end
			st_busy_done: begin
				if (bus_ready) begin
					flag_nx  = rx_byte;
					state_nx = st_busy_check;
				end
			end
			st_busy_check: begin
				// still busy: a fresh read frame
				if (busy_flag_q[busy_bit]) begin
					state_nx = st_busy_cmd;
				end else begin
					state_nx = ret_state;
				end
			end

			// refresh hold-off, then wait for the host
			st_hold_off: begin
				wait_max = timer_w'(wait_update - 1);
				if (wait_counter == wait_max) state_nx = st_idle;
			end
			st_idle: begin
				if (update_req && !update_ack_q) begin
					accept = 1'b1;
					if (READ_BUSY_FLAG != 0) begin
						state_nx = st_busy_cmd;
						ret_nx   = st_home_ctrl;
					end else begin
						state_nx = st_home_ctrl;
					end
				end
			end

			// return home, command 0x02
			st_home_ctrl: begin
				bus_enable = 1'b1;
				tx_byte    = {ctrl_command, 4'b1111};
				if (byte_next) state_nx = st_home_lo;
			end
			st_home_lo: begin
				bus_enable = 1'b1;
				tx_byte    = 8'h02;
				if (byte_next) state_nx = st_home_hi;
			end
			st_home_hi: begin
				bus_enable = 1'b1;
				tx_byte    = 8'h00;
				if (byte_next) state_nx = st_home_wait;
			end
			st_home_wait: begin
				if (bus_ready) begin
					if (READ_BUSY_FLAG != 0) begin
						state_nx = st_busy_cmd;
						ret_nx   = st_data_ctrl;
					end else begin
						wait_max = timer_w'(wait_cmd - 1);
						if (wait_counter == wait_max) state_nx = st_data_ctrl;
					end
				end
			end

			// data frame, two nibbles per character
			st_data_ctrl: begin
				bus_enable = 1'b1;
				tx_byte    = {ctrl_data, 4'b1111};
				if (byte_next) begin
					state_nx = st_data;
					write_nx = '0;
					cmd_nx   = '0;
				end
			end
			st_data: begin
				if (cmd_byte == 2'd2) begin
					write_nx = write_cycle + 1'b1;
					cmd_nx   = '0;
				end else if (write_cycle == LCD_SIZE) begin
					if (bus_ready) begin
						state_nx = st_hold_off;
						write_nx = '0;
						cmd_nx   = '0;
					end
				end else begin
					rd_addr    = char_addr_t'(write_cycle);
					bus_enable = 1'b1;
					// low nibble first
					if (cmd_byte == 2'd0) begin
						tx_byte = {4'b0000, rd_char[3:0]};
					end else begin
						tx_byte = {4'b0000, rd_char[7:4]};
					end
					if (byte_next) cmd_nx = cmd_byte + 1'b1;
				end
			end
			default: state_nx = st_wait_reset;
		endcase
	end

	assign update_ack = update_ack_q;
	assign busy_flag  = busy_flag_q;

endmodule

/* design/lcd_subsystem.sv */
/* LCD subsystem top: text buffer, serial master and controller
   everything runs on in_clk, no clock-domain crossing */
`timescale 1ns/1ns

module lcd_subsystem #(
	parameter int CLK_HZ         = 50000000,
	parameter int LCD_SIZE       = 80,
	parameter int READ_BUSY_FLAG = 1
) (
	input  logic                in_clk,
	input  logic                in_rst,
	input  logic                wr_en,
	input  lcd_pkg::char_addr_t wr_addr,
	input  lcd_pkg::char_t      wr_char,
	input  logic                update_req,
	output logic                update_ack,
	output lcd_pkg::bus_byte_t  busy_flag,
	output logic                lcd_reset_n,
	output logic                cs_n,
	output logic                sclk,
	output logic                sdo,
	input  logic                sdi
);
	import lcd_pkg::*;

	// byte bus between controller and serial master
	logic bus_enable;
	logic byte_next;
	logic bus_ready;
	bus_byte_t tx_byte;
	bus_byte_t rx_byte;

	// character read path
	char_addr_t rd_addr;
	char_t rd_char;

	text_buffer #(
		.LCD_SIZE(LCD_SIZE)
	) u_text_buffer (
		.in_clk(in_clk),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_char(wr_char),
		.rd_addr(rd_addr),
		.rd_char(rd_char)
	);

	serial_master u_serial_master (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.bus_enable(bus_enable),
		.tx_byte(tx_byte),
		.byte_next(byte_next),
		.bus_ready(bus_ready),
		.rx_byte(rx_byte),
		.cs_n(cs_n),
		.sclk(sclk),
		.sdo(sdo),
		.sdi(sdi)
	);

	lcd_3wire #(
		.CLK_HZ(CLK_HZ),
		.LCD_SIZE(LCD_SIZE),
		.READ_BUSY_FLAG(READ_BUSY_FLAG)
	) u_lcd_3wire (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.lcd_reset_n(lcd_reset_n),
		.update_req(update_req),
		.update_ack(update_ack),
		.bus_ready(bus_ready),
		.byte_next(byte_next),
		.bus_enable(bus_enable),
		.tx_byte(tx_byte),
		.rx_byte(rx_byte),
		.busy_flag(busy_flag),
		.rd_addr(rd_addr),
		.rd_char(rd_char)
	);

endmodule

/* verification/lcd_chk.sv */
/* protocol checks bound into lcd_subsystem, all on in_clk
   assumes the host holds update_req until it sees update_ack */
`timescale 1ns/1ns

module lcd_chk (
	input logic in_clk,
	input logic in_rst,
	input logic cs_n,
	input logic sclk,
	input logic sdo,
	input logic lcd_reset_n,
	input logic update_req,
	input logic update_ack,
	input logic bus_enable,
	input logic bus_ready,
	input logic byte_next
);
	// failed assertions so far
	int fail_count = 0;

	// ----------------------------------------
	// reset values
	// ----------------------------------------
	reset_values: assert property (@(posedge in_clk)
		in_rst |=> (cs_n && sclk && lcd_reset_n && !update_ack && !bus_enable && !byte_next))
		else begin
			$error("outputs not at their reset values");
			fail_count++;
		end

	// ----------------------------------------
	// serial line and byte bus
	// ----------------------------------------
	// sclk idles high whenever the chip is deselected
	sclk_idle: assert property (@(posedge in_clk) disable iff (in_rst) cs_n |-> sclk)
		else begin
			$error("sclk low while cs_n is high");
			fail_count++;
		end

	// sdo only moves on a falling sclk
	sdo_stable: assert property (@(posedge in_clk) disable iff (in_rst)
		(!cs_n && sclk && $past(sclk)) |-> $stable(sdo))
		else begin
			$error("sdo changed while sclk was high");
			fail_count++;
		end

	// byte latched one cycle after an idle master sees bus_enable
	next_latency: assert property (@(posedge in_clk) disable iff (in_rst)
		(bus_enable && bus_ready) |=> byte_next)
		else begin
			$error("byte_next missing one cycle after bus_enable");
			fail_count++;
		end

	next_pulse: assert property (@(posedge in_clk) disable iff (in_rst) byte_next |=> !byte_next)
		else begin
			$error("byte_next longer than one cycle");
			fail_count++;
		end

	// ----------------------------------------
	// four-phase refresh handshake
	// ----------------------------------------
	ack_after_req: assert property (@(posedge in_clk) disable iff (in_rst)
		$rose(update_ack) |-> ($past(update_req) && cs_n))
		else begin
			$error("update_ack rose without a request or during a frame");
			fail_count++;
		end

	ack_held: assert property (@(posedge in_clk) disable iff (in_rst)
		(update_ack && update_req) |=> update_ack)
		else begin
			$error("update_ack dropped while update_req was high");
			fail_count++;
		end

	ack_release: assert property (@(posedge in_clk) disable iff (in_rst)
		$fell(update_ack) |-> $past(!update_req))
		else begin
			$error("update_ack fell before update_req was released");
			fail_count++;
		end

endmodule

/* verification/lcd_tb.sv */
/* drives lcd_subsystem at CLK_HZ 100 kHz with busy-flag polling
   the LCD model decodes every sdo frame and answers status reads on sdi */
`timescale 1ns/1ns

module lcd_tb;
	import lcd_pkg::*;

	localparam int CLK_HZ = 100000;
	localparam int LCD_SIZE = 80;
	// power-up waits plus two refresh hold-offs
	localparam int wait_cycles = CLK_HZ / 20 + CLK_HZ / 2000 + CLK_HZ / 1000
		+ 2 * (CLK_HZ / 10);
	// init with up to four status reads per command, then two refreshes
	localparam int frame_bytes = init_num_commands * (3 + 4 * 2)
		+ 2 * (3 + 1 + 2 * LCD_SIZE + 4 * 4);
	localparam int timeout_limit = 2 * (wait_cycles + 32 * frame_bytes);

	logic in_clk = 1'b0;
	logic in_rst;
	logic wr_en;
	char_addr_t wr_addr;
	char_t wr_char;
	logic update_req;
	logic update_ack;
	bus_byte_t busy_flag;
	logic lcd_reset_n;
	logic cs_n;
	logic sclk;
	logic sdo;
	logic sdi = 1'b0;

	lcd_subsystem #(
		.CLK_HZ(CLK_HZ),
		.LCD_SIZE(LCD_SIZE),
		.READ_BUSY_FLAG(1)
	) dut (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_char(wr_char),
		.update_req(update_req),
		.update_ack(update_ack),
		.busy_flag(busy_flag),
		.lcd_reset_n(lcd_reset_n),
		.cs_n(cs_n),
		.sclk(sclk),
		.sdo(sdo),
		.sdi(sdi)
	);

	bind lcd_subsystem lcd_chk chk (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.cs_n(cs_n),
		.sclk(sclk),
		.sdo(sdo),
		.lcd_reset_n(lcd_reset_n),
		.update_req(update_req),
		.update_ack(update_ack),
		.bus_enable(bus_enable),
		.bus_ready(bus_ready),
		.byte_next(byte_next)
	);

	// 8 ns period
	always #4 in_clk = ~in_clk;

	// ----------------------------------------
	// LCD model state
	// ----------------------------------------
	bus_byte_t cur_byte;
	int bit_idx = 0;
	bus_byte_t frame_q[$];
	logic in_read = 1'b0;
	bus_byte_t reply = '0;
	int busy_left = 0;
	logic last_busy = 1'b0;
	int busy_replies = 0;
	// last status byte sent back, once there is one
	logic flag_seen = 1'b0;
	bus_byte_t flag_exp = '0;
	// frames other than status reads
	int cmd_frames = 0;
	int data_frames = 0;
	logic after_home = 1'b0;
	char_t exp_text [0:LCD_SIZE-1];
	int err_count = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int test_errs = 0;
	int cycle_count = 0;

	task automatic report_mismatch(input string msg);
		$display("FAILED %0t: %s", $time, msg);
		err_count++;
	endtask

	// status byte for this read, busy until the poll budget is used up
	task automatic start_reply();
		in_read = 1'b1;
		reply = bus_byte_t'($urandom);
		reply[busy_bit] = (busy_left > 0);
		if (busy_left > 0) begin
			busy_left--;
			busy_replies++;
		end
		last_busy = reply[busy_bit];
	endtask

	task automatic check_frame();
		bus_byte_t ctrl;
		int n;
		int idx;
		int bad;
		int first_bad;
		ctrl = frame_q[0];
		n = frame_q.size();
		// busy_flag still shows the previous status byte when a frame ends
		if (flag_seen) begin
			assert (busy_flag === flag_exp)
			else report_mismatch($sformatf("busy_flag %h, last status byte %h",
				busy_flag, flag_exp));
		end
		if (ctrl == {ctrl_read, 4'b1111}) begin
			in_read = 1'b0;
			assert (n == 2) else report_mismatch($sformatf("status read of %0d bytes", n));
			flag_exp = reply;
			flag_seen = 1'b1;
		end else begin
			// a busy reply has to be followed by another read
			assert (!last_busy) else report_mismatch("frame sent while the LCD was busy");
			if (cmd_frames < init_num_commands) begin
				idx = 3 * cmd_frames;
				assert (n == 3 && ctrl == {init_table[idx], 4'b1111}
					&& frame_q[1] == {4'b0000, init_table[idx + 1]}
					&& frame_q[2] == {4'b0000, init_table[idx + 2]})
				else report_mismatch($sformatf("init command %0d: %0d bytes %h %h %h",
					cmd_frames, n, ctrl, frame_q[1], frame_q[2]));
			end else if (ctrl == {ctrl_command, 4'b1111}) begin
				// return home is instruction 0x02
				assert (n == 3 && frame_q[1] == 8'h02 && frame_q[2] == 8'h00)
				else report_mismatch("return-home frame has wrong payload");
				after_home = 1'b1;
			end else begin
				bad = 0;
				first_bad = -1;
				// low nibble first, address order
				for (int a = 0; a < LCD_SIZE; a++) begin
					if (frame_q[1 + 2 * a] !== {4'b0000, exp_text[a][3:0]}
						|| frame_q[2 + 2 * a] !== {4'b0000, exp_text[a][7:4]}) begin
						bad++;
						if (first_bad < 0) begin
							first_bad = a;
						end
					end
				end
				assert (ctrl == {ctrl_data, 4'b1111} && after_home)
				else report_mismatch($sformatf("unexpected frame, control byte %h", ctrl));
				assert (n == 1 + 2 * LCD_SIZE && bad == 0)
				else report_mismatch($sformatf("data frame: %0d bytes, %0d chars wrong from %0d",
					n, bad, first_bad));
				after_home = 1'b0;
				data_frames++;
			end
			cmd_frames++;
			busy_left = $urandom_range(3, 0);
		end
	endtask

	// ----------------------------------------
	// LCD model, sdo sampled on rising sclk
	// ----------------------------------------
	always @(posedge sclk or posedge cs_n) begin
		if (cs_n === 1'b0) begin
			cur_byte = {sdo, cur_byte[7:1]};
			bit_idx = bit_idx + 1;
			if (bit_idx == 8) begin
				bit_idx = 0;
				frame_q.push_back(cur_byte);
				if (frame_q.size() == 1 && cur_byte == {ctrl_read, 4'b1111}) begin
					start_reply();
				end
			end
		end else if (cs_n === 1'b1 && frame_q.size() > 0) begin
			check_frame();
			frame_q.delete();
			bit_idx = 0;
		end
	end

	// status bits go out on falling sclk during the second byte
	always @(negedge sclk) begin
		if (cs_n === 1'b0 && in_read && frame_q.size() == 1) begin
			sdi <= reply[bit_idx];
		end
	end

	// ----------------------------------------
	// host side
	// ----------------------------------------
	task automatic end_test(input string name);
		tests_run++;
		if (err_count > test_errs) begin
			tests_failed++;
			$display("test %0d %s: failed", tests_run, name);
		end else begin
			$display("test %0d %s: ok", tests_run, name);
		end
		test_errs = err_count;
	endtask

	task automatic write_text();
		for (int a = 0; a < LCD_SIZE; a++) begin
			@(negedge in_clk);
			wr_en = 1'b1;
			wr_addr = char_addr_t'(a);
			wr_char = char_t'($urandom);
			exp_text[a] = wr_char;
		end
		@(negedge in_clk);
		wr_en = 1'b0;
	endtask

	task automatic await_ack(input logic level);
		while (update_ack !== level) begin
			@(negedge in_clk);
		end
	endtask

	initial begin
		int low_cycles;
		int chk_errs;
		logic early_ack;
		void'($urandom(14499));
		in_rst = 1'b1;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_char = '0;
		update_req = 1'b0;
		repeat (5) @(negedge in_clk);
		in_rst = 1'b0;

		// power-up, one 500 us reset pulse
		assert (cs_n === 1'b1 && sclk === 1'b1 && lcd_reset_n === 1'b1 && update_ack === 1'b0)
		else report_mismatch("outputs not idle after reset");
		while (lcd_reset_n !== 1'b0) begin
			@(negedge in_clk);
		end
		low_cycles = 0;
		while (lcd_reset_n === 1'b0) begin
			low_cycles++;
			@(negedge in_clk);
		end
		assert (low_cycles == CLK_HZ / 2000)
		else report_mismatch($sformatf("reset pulse of %0d cycles", low_cycles));
		end_test("power-up reset");

		// init frames are checked by the model as they end
		while (cmd_frames < init_num_commands) begin
			@(negedge in_clk);
		end
		end_test("init sequence");

		assert (busy_replies > 0) else report_mismatch("the model never answered busy");
		end_test("busy polling");

		write_text();
		update_req = 1'b1;
		await_ack(1'b1);
		update_req = 1'b0;
		await_ack(1'b0);
		// next request raised while this refresh is still running
		update_req = 1'b1;
		early_ack = 1'b0;
		while (data_frames < 1) begin
			@(negedge in_clk);
			if (update_ack === 1'b1) begin
				early_ack = 1'b1;
			end
		end
		end_test("refresh");

		// new text lands during the hold-off
		write_text();
		await_ack(1'b1);
		assert (!early_ack && data_frames == 1 && cs_n === 1'b1)
		else report_mismatch("second request acknowledged before the refresh ended");
		update_req = 1'b0;
		await_ack(1'b0);
		while (data_frames < 2) begin
			@(negedge in_clk);
		end
		end_test("request during refresh");

		chk_errs = dut.chk.fail_count;
		$display("tests run %0d, tests failed %0d, value errors %0d, checker errors %0d",
			tests_run, tests_failed, err_count, chk_errs);
		if (chk_errs > 0) begin
			$display("protocol checker flagged %0d assertion failures", chk_errs);
		end
		if (tests_failed == 0 && err_count == 0 && chk_errs == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// run limit in clock cycles
	always @(posedge in_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_limit) begin
			$display("timeout: run did not finish within %0d cycles", timeout_limit);
			$display("TEST FAILED");
			$finish;
		end
	end

endmodule

/* lcd_serial.f */
// design sources, package first
design/lcd_pkg.sv
design/text_buffer.sv
design/serial_master.sv
design/lcd_3wire.sv
design/lcd_subsystem.sv
// testbench and bound checker
verification/lcd_chk.sv
verification/lcd_tb.sv

/* Bender.yml */
package:
  name: lcd_serial

# compile order matches lcd_serial.f
sources:
  # design, package first
  - files:
      - design/lcd_pkg.sv
      - design/text_buffer.sv
      - design/serial_master.sv
      - design/lcd_3wire.sv
      - design/lcd_subsystem.sv

  # testbench with the bound protocol checker
  - target: test
    files:
      - verification/lcd_chk.sv
      - verification/lcd_tb.sv
